//--- hdl/tlb_params.svh
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// TLB geometry
`define TLB_ENTRIES 32

// Field widths of an entry, in CP0 register terms
`define VPN2_W 19
`define ASID_W 8
`define PFN_W 20

// Address layout
`define PAGE_OFS_W 12
`define VADDR_W 32

// Addresses with this bit set bypass translation
`define KSEG_BIT 31

`endif

//--- hdl/tlb_pkg.sv
`default_nettype none

`include "tlb_params.svh"

package tlb_pkg;

	// Entry fields
	typedef logic [`VPN2_W-1:0] vpn2_t;
	typedef logic [`ASID_W-1:0] asid_t;
	typedef logic [`PFN_W-1:0] pfn_t;

	// C field of EntryLo
	typedef logic [2:0] cache_attr_t;

	// One bit per entry, and an index into the entries
	typedef logic [$clog2(`TLB_ENTRIES)-1:0] tlb_index_t;
	typedef logic [`TLB_ENTRIES-1:0] hit_vec_t;

	// Addresses
	typedef logic [`VADDR_W-1:0] vaddr_t;
	typedef logic [`VADDR_W-1:0] paddr_t;

	// EntryHi / EntryLo register format
	typedef logic [31:0] entry_word_t;

endpackage

`default_nettype wire

//--- hdl/tlb_cmd_pkg.sv
`default_nettype none

package tlb_cmd_pkg;

	// Command and response operation
	typedef enum logic [1:0] {
		op_write = 2'd0,
		op_probe = 2'd1,
		op_translate = 2'd2
	} tlb_op_e;

	// Occupancy of a single-entry pipeline stage
	typedef enum logic {
		st_empty = 1'b0,
		st_full = 1'b1
	} stage_state_e;

endpackage

`default_nettype wire

//--- hdl/tlb_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// Decode to execute
interface tlb_req_if;
	import tlb_pkg::*;
	import tlb_cmd_pkg::*;

	logic valid;
	logic ready;
	tlb_op_e op;
	tlb_index_t index;
	vpn2_t vpn2;
	asid_t asid;
	logic odd;
	vaddr_t vaddr;
	pfn_t pfn0;
	cache_attr_t attr0;
	logic dirty0;
	logic valid0;
	pfn_t pfn1;
	cache_attr_t attr1;
	logic dirty1;
	logic valid1;
	logic is_global;

	modport decode_mp (
		output valid, op, index, vpn2, asid, odd, vaddr,
		output pfn0, attr0, dirty0, valid0, pfn1, attr1, dirty1, valid1, is_global,
		input ready
	);

	modport exec_mp (
		input valid, op, index, vpn2, asid, odd, vaddr,
		input pfn0, attr0, dirty0, valid0, pfn1, attr1, dirty1, valid1, is_global,
		output ready
	);
endinterface

// Execute to result
interface tlb_match_if;
	import tlb_pkg::*;
	import tlb_cmd_pkg::*;

	logic valid;
	logic ready;
	tlb_op_e op;
	vaddr_t vaddr;
	logic hit;
	tlb_index_t hit_index;
	pfn_t pfn;
	logic dirty;
	logic page_valid;

	modport exec_mp (output valid, op, vaddr, hit, hit_index, pfn, dirty, page_valid, input ready);
	modport result_mp (input valid, op, vaddr, hit, hit_index, pfn, dirty, page_valid, output ready);
endinterface

`default_nettype wire

//--- hdl/tlb_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_params.svh"

module tlb_decode (
	input wire logic clk,
	input wire logic rst,
	input wire logic cmd_valid,
	output logic cmd_ready,
	input tlb_cmd_pkg::tlb_op_e cmd_op,
	input tlb_pkg::tlb_index_t cmd_index,
	input tlb_pkg::entry_word_t cmd_entryhi,
	input tlb_pkg::entry_word_t cmd_entrylo0,
	input tlb_pkg::entry_word_t cmd_entrylo1,
	input tlb_pkg::vaddr_t cmd_vaddr,
	tlb_req_if.decode_mp req
);
	import tlb_cmd_pkg::*;

	stage_state_e state;
	logic take;
	logic is_translate;

	assign cmd_ready = (state == st_empty) || req.ready;
	assign take = cmd_valid && cmd_ready;
	assign is_translate = (cmd_op == op_translate);
	assign req.valid = (state == st_full);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_empty;
		end else if (take) begin
			state <= st_full;
		end else if (req.ready) begin
			state <= st_empty;
		end
	end

	// Holding register, split into entry fields on capture
	always_ff @(posedge clk) begin
		if (take) begin
			req.op <= cmd_op;
			req.index <= cmd_index;
			req.vaddr <= cmd_vaddr;
			// Translate looks up the page of vaddr under the current ASID
			req.vpn2 <= is_translate ? cmd_vaddr[`VADDR_W-1 -: `VPN2_W]
				: cmd_entryhi[31 -: `VPN2_W];
			req.odd <= is_translate && cmd_vaddr[`PAGE_OFS_W];
			req.asid <= cmd_entryhi[`ASID_W-1:0];
			req.pfn0 <= cmd_entrylo0[`PFN_W+5:6];
			req.attr0 <= cmd_entrylo0[5:3];
			req.dirty0 <= cmd_entrylo0[2];
			req.valid0 <= cmd_entrylo0[1];
			req.pfn1 <= cmd_entrylo1[`PFN_W+5:6];
			req.attr1 <= cmd_entrylo1[5:3];
			req.dirty1 <= cmd_entrylo1[2];
			req.valid1 <= cmd_entrylo1[1];
			req.is_global <= cmd_entrylo0[0] & cmd_entrylo1[0];
		end
	end

	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		req.valid && !req.ready |=> req.valid && $stable(req.op) && $stable(req.index)
			&& $stable(req.vpn2) && $stable(req.asid) && $stable(req.vaddr));

endmodule

`default_nettype wire

//--- hdl/tlb_entry_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_params.svh"

module tlb_entry_array (
	input wire logic clk,
	input wire logic rst,
	tlb_req_if.exec_mp req,
	tlb_match_if.exec_mp match
);
	import tlb_pkg::*;
	import tlb_cmd_pkg::*;

	// Entry storage
	vpn2_t ent_vpn2 [`TLB_ENTRIES];
	asid_t ent_asid [`TLB_ENTRIES];
	logic ent_global [`TLB_ENTRIES];
	pfn_t ent_pfn0 [`TLB_ENTRIES];
	pfn_t ent_pfn1 [`TLB_ENTRIES];
	logic ent_dirty0 [`TLB_ENTRIES];
	logic ent_dirty1 [`TLB_ENTRIES];
	logic ent_pvalid0 [`TLB_ENTRIES];
	logic ent_pvalid1 [`TLB_ENTRIES];
	hit_vec_t ent_valid;

	hit_vec_t hit_vec;
	tlb_index_t hit_idx;
	stage_state_e state;
	logic take;
	logic write_en;

	assign req.ready = (state == st_empty) || match.ready;
	assign take = req.valid && req.ready;
	assign write_en = take && (req.op == op_write);
	assign match.valid = (state == st_full);

	// Parallel compare against every entry
	always_comb begin
		for (int i = 0; i < `TLB_ENTRIES; i++) begin
			hit_vec[i] = ent_valid[i] && (ent_vpn2[i] == req.vpn2)
				&& (ent_global[i] || (ent_asid[i] == req.asid));
		end
	end

	// Lowest matching index wins
	always_comb begin
		hit_idx = '0;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				hit_idx = tlb_index_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			ent_vpn2[req.index] <= req.vpn2;
			ent_asid[req.index] <= req.asid;
			ent_global[req.index] <= req.is_global;
			ent_pfn0[req.index] <= req.pfn0;
			ent_dirty0[req.index] <= req.dirty0;
			ent_pvalid0[req.index] <= req.valid0;
			ent_pfn1[req.index] <= req.pfn1;
			ent_dirty1[req.index] <= req.dirty1;
			ent_pvalid1[req.index] <= req.valid1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
		end else if (write_en) begin
			ent_valid[req.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_empty;
		end else if (take) begin
			state <= st_full;
		end else if (match.ready) begin
			state <= st_empty;
		end
	end

	// Selected even or odd half goes forward
	always_ff @(posedge clk) begin
		if (take) begin
			match.op <= req.op;
			match.vaddr <= req.vaddr;
			match.hit <= |hit_vec;
			match.hit_index <= hit_idx;
			match.pfn <= req.odd ? ent_pfn1[hit_idx] : ent_pfn0[hit_idx];
			match.dirty <= req.odd ? ent_dirty1[hit_idx] : ent_dirty0[hit_idx];
			match.page_valid <= req.odd ? ent_pvalid1[hit_idx] : ent_pvalid0[hit_idx];
		end
	end

	// Registered index hits and no lower entry hits
	a_lowest_hit: assert property (@(posedge clk) disable iff (rst)
		take && (|hit_vec) |-> hit_vec[hit_idx]
			&& ((hit_vec & ((hit_vec_t'(1) << hit_idx) - hit_vec_t'(1))) == '0));

endmodule

`default_nettype wire

//--- hdl/tlb_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_params.svh"

module tlb_result (
	input wire logic clk,
	input wire logic rst,
	tlb_match_if.result_mp match,
	output logic rsp_valid,
	input wire logic rsp_ready,
	output tlb_cmd_pkg::tlb_op_e rsp_op,
	output tlb_pkg::paddr_t rsp_paddr,
	output logic rsp_refill,
	output logic rsp_invalid,
	output logic rsp_modified,
	output logic rsp_found,
	output tlb_pkg::tlb_index_t rsp_index
);
	import tlb_pkg::*;
	import tlb_cmd_pkg::*;

	stage_state_e state;
	logic take;
	logic mapped;
	logic found;
	paddr_t paddr;

	assign match.ready = (state == st_empty) || rsp_ready;
	assign take = match.valid && match.ready;
	assign rsp_valid = (state == st_full);

	// Only translates below the unmapped boundary go through the TLB
	assign mapped = (match.op == op_translate) && !match.vaddr[`KSEG_BIT];
	assign found = (match.op == op_probe) && match.hit;

	always_comb begin
		paddr = '0;
		if (match.op == op_translate) begin
			if (!mapped) begin
				paddr = match.vaddr;
			end else if (match.hit) begin
				paddr = {match.pfn, match.vaddr[`PAGE_OFS_W-1:0]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_empty;
		end else if (take) begin
			state <= st_full;
		end else if (rsp_ready) begin
			state <= st_empty;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rsp_op <= match.op;
			rsp_paddr <= paddr;
			rsp_refill <= mapped && !match.hit;
			rsp_invalid <= mapped && match.hit && !match.page_valid;
			rsp_modified <= mapped && match.hit && match.page_valid && !match.dirty;
			rsp_found <= found;
			rsp_index <= found ? match.hit_index : '0;
		end
	end

	// Execute keeps its output while this stage stalls
	a_match_hold: assert property (@(posedge clk) disable iff (rst)
		match.valid && !match.ready |=> match.valid && $stable(match.op)
			&& $stable(match.vaddr) && $stable(match.hit) && $stable(match.hit_index)
			&& $stable(match.pfn) && $stable(match.dirty) && $stable(match.page_valid));

	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_op) && $stable(rsp_paddr)
			&& $stable(rsp_refill) && $stable(rsp_invalid) && $stable(rsp_modified)
			&& $stable(rsp_found) && $stable(rsp_index));

endmodule

`default_nettype wire

//--- hdl/tlb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_top (
	input wire logic clk,
	input wire logic rst,

	// Command port
	input wire logic cmd_valid,
	output logic cmd_ready,
	input tlb_cmd_pkg::tlb_op_e cmd_op,
	input tlb_pkg::tlb_index_t cmd_index,
	input tlb_pkg::entry_word_t cmd_entryhi,
	input tlb_pkg::entry_word_t cmd_entrylo0,
	input tlb_pkg::entry_word_t cmd_entrylo1,
	input tlb_pkg::vaddr_t cmd_vaddr,

	// Response port
	output logic rsp_valid,
	input wire logic rsp_ready,
	output tlb_cmd_pkg::tlb_op_e rsp_op,
	output tlb_pkg::paddr_t rsp_paddr,
	output logic rsp_refill,
	output logic rsp_invalid,
	output logic rsp_modified,
	output logic rsp_found,
	output tlb_pkg::tlb_index_t rsp_index
);

	tlb_req_if req_if ();
	tlb_match_if match_if ();

	tlb_decode tlb_decode_i (
		.clk (clk),
		.rst (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_op (cmd_op),
		.cmd_index (cmd_index),
		.cmd_entryhi (cmd_entryhi),
		.cmd_entrylo0 (cmd_entrylo0),
		.cmd_entrylo1 (cmd_entrylo1),
		.cmd_vaddr (cmd_vaddr),
		.req (req_if.decode_mp)
	);

	tlb_entry_array tlb_entry_array_i (
		.clk (clk),
		.rst (rst),
		.req (req_if.exec_mp),
		.match (match_if.exec_mp)
	);

	tlb_result tlb_result_i (
		.clk (clk),
		.rst (rst),
		.match (match_if.result_mp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_op (rsp_op),
		.rsp_paddr (rsp_paddr),
		.rsp_refill (rsp_refill),
		.rsp_invalid (rsp_invalid),
		.rsp_modified (rsp_modified),
		.rsp_found (rsp_found),
		.rsp_index (rsp_index)
	);

endmodule

`default_nettype wire

//--- tb/tb_tlb.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_params.svh"

module tb_tlb;
	import tlb_pkg::*;
	import tlb_cmd_pkg::*;

	logic clk;
	logic rst;
	logic cmd_valid;
	logic cmd_ready;
	tlb_op_e cmd_op;
	tlb_index_t cmd_index;
	entry_word_t cmd_entryhi;
	entry_word_t cmd_entrylo0;
	entry_word_t cmd_entrylo1;
	vaddr_t cmd_vaddr;
	logic rsp_valid;
	logic rsp_ready;
	tlb_op_e rsp_op;
	paddr_t rsp_paddr;
	logic rsp_refill;
	logic rsp_invalid;
	logic rsp_modified;
	logic rsp_found;
	tlb_index_t rsp_index;

	// Reference copy of the entries, kept as raw CP0 words
	entry_word_t m_hi [`TLB_ENTRIES];
	entry_word_t m_lo0 [`TLB_ENTRIES];
	entry_word_t m_lo1 [`TLB_ENTRIES];
	logic m_valid [`TLB_ENTRIES];

	// Expected responses in command order
	tlb_op_e exp_op_q [$];
	paddr_t exp_paddr_q [$];
	logic [2:0] exp_flag_q [$];
	logic exp_found_q [$];
	tlb_index_t exp_index_q [$];

	logic [31:0] stim_lfsr;
	logic [31:0] bp_lfsr;
	logic hold_ready;
	int edge_cnt;
	int accept_edge;

	tlb_top tlb_top_i (
		.clk (clk),
		.rst (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_op (cmd_op),
		.cmd_index (cmd_index),
		.cmd_entryhi (cmd_entryhi),
		.cmd_entrylo0 (cmd_entrylo0),
		.cmd_entrylo1 (cmd_entrylo1),
		.cmd_vaddr (cmd_vaddr),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_op (rsp_op),
		.rsp_paddr (rsp_paddr),
		.rsp_refill (rsp_refill),
		.rsp_invalid (rsp_invalid),
		.rsp_modified (rsp_modified),
		.rsp_found (rsp_found),
		.rsp_index (rsp_index)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
	end

	// Galois LFSR, one step per bit returned
	function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
		logic [31:0] r;
		logic bit_out;
		r = '0;
		for (int i = 0; i < n; i++) begin
			bit_out = state[0];
			state = state >> 1;
			if (bit_out) begin
				state = state ^ 32'hA300_0000;
			end
			r = {r[30:0], bit_out};
		end
		return r;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic mismatch(input string msg);
		abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
	endtask

	// Expected response from the joint TLB rules, lowest matching index wins
	function automatic void predict(input tlb_op_e op, input tlb_index_t index,
		input entry_word_t hi, input entry_word_t lo0, input entry_word_t lo1,
		input vaddr_t vaddr);
		vpn2_t vpn2;
		asid_t asid;
		entry_word_t lo;
		int hit;
		paddr_t paddr;
		logic [2:0] flags;
		vpn2 = (op == op_translate) ? vaddr[31:13] : hi[31:13];
		asid = hi[7:0];
		hit = -1;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
			if (m_valid[i] && (m_hi[i][31:13] == vpn2)
				&& ((m_lo0[i][0] && m_lo1[i][0]) || (m_hi[i][7:0] == asid))) begin
				hit = i;
			end
		end
		paddr = '0;
		flags = '0;
		if (op == op_write) begin
			m_hi[index] = hi;
			m_lo0[index] = lo0;
			m_lo1[index] = lo1;
			m_valid[index] = 1'b1;
		end else if (op == op_translate) begin
			if (vaddr[31]) begin
				paddr = vaddr;
			end else if (hit < 0) begin
				flags = 3'b100;
			end else begin
				lo = vaddr[12] ? m_lo1[hit] : m_lo0[hit];
				paddr = {lo[25:6], vaddr[11:0]};
				flags = {1'b0, !lo[1], lo[1] && !lo[2]};
			end
		end
		exp_op_q.push_back(op);
		exp_paddr_q.push_back(paddr);
		exp_flag_q.push_back(flags);
		exp_found_q.push_back((op == op_probe) && (hit >= 0));
		exp_index_q.push_back(((op == op_probe) && (hit >= 0)) ? tlb_index_t'(hit) : '0);
	endfunction

	task automatic check_translate(input paddr_t exp_paddr, input logic [2:0] exp_flags);
		if (rsp_op != op_translate || rsp_paddr != exp_paddr
			|| {rsp_refill, rsp_invalid, rsp_modified} != exp_flags
			|| rsp_found || rsp_index != '0) begin
			mismatch($sformatf("translate expected paddr %h flags %b, got op %0d paddr %h flags %b",
				exp_paddr, exp_flags, rsp_op, rsp_paddr, {rsp_refill, rsp_invalid, rsp_modified}));
		end
	endtask

	task automatic check_probe(input logic exp_found, input tlb_index_t exp_index);
		if (rsp_op != op_probe || rsp_found != exp_found || rsp_index != exp_index
			|| rsp_paddr != '0 || {rsp_refill, rsp_invalid, rsp_modified} != 3'b000) begin
			mismatch($sformatf("probe expected found %b index %0d, got op %0d found %b index %0d",
				exp_found, exp_index, rsp_op, rsp_found, rsp_index));
		end
	endtask

	task automatic check_write(input tlb_op_e exp_op);
		if (rsp_op != exp_op || rsp_paddr != '0 || rsp_refill || rsp_invalid
			|| rsp_modified || rsp_found || rsp_index != '0) begin
			mismatch($sformatf("write expected op %0d and zero fields, got op %0d paddr %h",
				exp_op, rsp_op, rsp_paddr));
		end
	endtask

	task automatic compare_response();
		tlb_op_e op;
		paddr_t paddr;
		logic [2:0] flags;
		logic found;
		tlb_index_t index;
		if (exp_op_q.size() == 0) begin
			abort_run("A response arrived with no command outstanding");
		end
		op = exp_op_q.pop_front();
		paddr = exp_paddr_q.pop_front();
		flags = exp_flag_q.pop_front();
		found = exp_found_q.pop_front();
		index = exp_index_q.pop_front();
		case (op)
			op_translate: check_translate(paddr, flags);
			op_probe: check_probe(found, index);
			default: check_write(op);
		endcase
	endtask

	// Comparison process, samples one ns before each rising edge
	initial begin
		forever begin
			@(negedge clk);
			#1;
			if (!rst && rsp_valid && rsp_ready) begin
				compare_response();
			end
			if (!rst && cmd_valid && cmd_ready) begin
				predict(cmd_op, cmd_index, cmd_entryhi, cmd_entrylo0, cmd_entrylo1, cmd_vaddr);
			end
		end
	end

	// Random back-pressure unless held ready
	always @(negedge clk) begin
		if (hold_ready) begin
			rsp_ready = 1'b1;
		end else begin
			rsp_ready = (rand_bits(bp_lfsr, 1) != 0);
		end
	end

	task automatic send_cmd(input tlb_op_e op, input tlb_index_t index, input entry_word_t hi,
		input entry_word_t lo0, input entry_word_t lo1, input vaddr_t vaddr);
		int waited;
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_index = index;
		cmd_entryhi = hi;
		cmd_entrylo0 = lo0;
		cmd_entrylo1 = lo1;
		cmd_vaddr = vaddr;
		waited = 0;
		#1;
		while (!cmd_ready) begin
			waited++;
			if (waited > 100) begin
				abort_run("Timeout: cmd_ready stayed low for 100 cycles");
			end
			@(negedge clk);
			#1;
		end
		accept_edge = edge_cnt;
		@(posedge clk);
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	// G in EntryLo0 alone must not make the entry global
	task automatic random_write(output vpn2_t vpn2, output asid_t asid);
		entry_word_t lo0;
		entry_word_t lo1;
		tlb_index_t index;
		logic make_global;
		vpn2 = vpn2_t'(rand_bits(stim_lfsr, 3));
		asid = asid_t'(rand_bits(stim_lfsr, 2));
		make_global = (rand_bits(stim_lfsr, 2) == 0);
		lo0 = rand_bits(stim_lfsr, 26);
		lo1 = rand_bits(stim_lfsr, 26);
		index = tlb_index_t'(rand_bits(stim_lfsr, 5));
		lo0[0] = lo0[0] || make_global;
		lo1[0] = make_global;
		send_cmd(op_write, index, {vpn2, 5'b0, asid}, lo0, lo1, '0);
	endtask

	task automatic translate_page(input vpn2_t vpn2, input asid_t asid);
		entry_word_t hi;
		vaddr_t va;
		va = {vpn2, 13'b0} | rand_bits(stim_lfsr, 13);
		hi = (rand_bits(stim_lfsr, 24) << 8) | {24'b0, asid};
		send_cmd(op_translate, '0, hi, '0, '0, va);
	endtask

	task automatic translate_unmapped();
		vaddr_t va;
		va = 32'h8000_0000 | rand_bits(stim_lfsr, 31);
		send_cmd(op_translate, '0, '0, '0, '0, va);
	endtask

	task automatic probe_page(input vpn2_t vpn2, input asid_t asid);
		tlb_index_t index;
		index = tlb_index_t'(rand_bits(stim_lfsr, 5));
		send_cmd(op_probe, index, {vpn2, 5'b0, asid}, '0, '0, '0);
	endtask

	task automatic wait_drain();
		int waited;
		idle_cycle();
		waited = 0;
		while (exp_op_q.size() != 0) begin
			waited++;
			if (waited > 200) begin
				abort_run("Timeout: responses still outstanding after 200 cycles");
			end
			@(posedge clk);
		end
	endtask

	// Single command with rsp_ready high, response three edges after acceptance
	task automatic check_latency();
		int start;
		int waited;
		hold_ready = 1'b1;
		wait_drain();
		translate_page(vpn2_t'(3), asid_t'(1));
		start = accept_edge;
		@(negedge clk);
		cmd_valid = 1'b0;
		#1;
		waited = 0;
		while (!rsp_valid) begin
			waited++;
			if (waited > 10) begin
				abort_run("Timeout: no response to the latency command");
			end
			@(negedge clk);
			#1;
		end
		if (edge_cnt - start != 3) begin
			mismatch($sformatf("response %0d edges after acceptance, expected 3",
				edge_cnt - start));
		end
		hold_ready = 1'b0;
	endtask

	initial begin
		vpn2_t vpn2;
		asid_t asid;
		logic [31:0] sel;
		clk = 1'b0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = op_write;
		cmd_index = '0;
		cmd_entryhi = '0;
		cmd_entrylo0 = '0;
		cmd_entrylo1 = '0;
		cmd_vaddr = '0;
		rsp_ready = 1'b0;
		hold_ready = 1'b0;
		edge_cnt = 0;
		accept_edge = 0;
		stim_lfsr = 32'd63;
		bp_lfsr = 32'd63;
		for (int i = 0; i < `TLB_ENTRIES; i++) begin
			m_valid[i] = 1'b0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		if (!cmd_ready || rsp_valid) begin
			mismatch("pipeline not idle after reset");
		end

		// Empty TLB, every mapped lookup misses
		for (int n = 0; n < 8; n++) begin
			vpn2 = vpn2_t'(rand_bits(stim_lfsr, 3));
			asid = asid_t'(rand_bits(stim_lfsr, 2));
			translate_page(vpn2, asid);
			probe_page(vpn2, asid);
		end

		for (int n = 0; n < 48; n++) begin
			random_write(vpn2, asid);
		end

		// Mixed traffic with idle gaps
		for (int n = 0; n < 300; n++) begin
			sel = rand_bits(stim_lfsr, 3);
			vpn2 = vpn2_t'(rand_bits(stim_lfsr, 3));
			asid = asid_t'(rand_bits(stim_lfsr, 2));
			case (sel)
				0, 1: random_write(vpn2, asid);
				2, 3: probe_page(vpn2, asid);
				7: translate_unmapped();
				default: translate_page(vpn2, asid);
			endcase
			if (rand_bits(stim_lfsr, 2) == 0) begin
				idle_cycle();
			end
		end

		// Write immediately followed by a lookup of the same page
		for (int n = 0; n < 16; n++) begin
			random_write(vpn2, asid);
			translate_page(vpn2, asid);
		end

		check_latency();
		wait_drain();
		@(negedge clk);
		#1;
		if (rsp_valid || !cmd_ready) begin
			mismatch("pipeline not idle at end of run");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tlb.f
+incdir+hdl
hdl/tlb_pkg.sv
hdl/tlb_cmd_pkg.sv
hdl/tlb_ifs.sv
hdl/tlb_decode.sv
hdl/tlb_entry_array.sv
hdl/tlb_result.sv
hdl/tlb_top.sv
tb/tb_tlb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the TLB testbench with Verilator, run it, and search the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_tlb -f tlb.f \
	&& ./obj_dir/Vtb_tlb 2>&1 | tee sim.log

grep -q "^>>> PASS$" sim.log \
	&& echo "Simulation passed" \
	&& exit 0 \
	|| { echo "Simulation failed"; exit 1; }
